// File: rtl/pcie_app_settings.svh
// widths and depths for the pcie application block, included wherever a size is needed
`ifndef PCIE_APP_SETTINGS_SVH
`define PCIE_APP_SETTINGS_SVH

// stream word and apb data width
`define APP_DATA_W 32

// apb byte address width
`define APP_ADDR_W 12

// entries in each configuration engine fifo
`define APP_FIFO_DEPTH 4

`endif

// File: rtl/pcie_app_pkg.sv
// register map and path mode types shared by the pcie application modules
`default_nettype none

`include "pcie_app_settings.svh"

package pcie_app_pkg;

    // apb register byte offsets
    typedef enum logic [`APP_ADDR_W-1:0]
    {
        REG_CTRL    = 'h000,    // bit 0 requested mode
        REG_STATUS  = 'h004,    // active mode, tx full, rx not empty
        REG_TX_DATA = 'h008,    // push, last clear
        REG_TX_LAST = 'h00C,    // push, last set
        REG_RX_DATA = 'h010,    // pop head word
        REG_RX_PKTS = 'h014,    // write clears count and checksum
        REG_RX_CSUM = 'h018
    } reg_addr_e;

    // which side owns the stream path
    typedef enum logic
    {
        MODE_DMA = 1'b0,
        MODE_CFG = 1'b1
    } path_mode_e;

endpackage

`default_nettype wire

// File: rtl/app_stream_if.sv
// valid/ready word stream and the register-to-engine access bundle used inside the design
`default_nettype none

`include "pcie_app_settings.svh"

interface app_stream_if;

    logic                   tvalid;
    logic                   tready;
    logic [`APP_DATA_W-1:0] tdata;
    logic                   tlast;     // final word of a packet

    modport src
    (
        output tvalid,
        output tdata,
        output tlast,
        input  tready
    );

    modport snk
    (
        input  tvalid,
        input  tdata,
        input  tlast,
        output tready
    );

endinterface

interface cfg_access_if;

    logic                   push;      // one word into the tx fifo
    logic [`APP_DATA_W-1:0] push_data;
    logic                   push_last;
    logic                   pop;       // one word out of the rx fifo
    logic [`APP_DATA_W-1:0] pop_data;  // rx fifo head
    logic                   tx_full;
    logic                   rx_nempty;

    modport regs
    (
        output push,
        output push_data,
        output push_last,
        output pop,
        input  pop_data,
        input  tx_full,
        input  rx_nempty
    );

    modport engine
    (
        input  push,
        input  push_data,
        input  push_last,
        input  pop,
        output pop_data,
        output tx_full,
        output rx_nempty
    );

endinterface

`default_nettype wire

// File: rtl/app_regs.sv
// apb register slave: mode control, status, tx/rx data ports and receive counters
`default_nettype none

`include "pcie_app_settings.svh"

module app_regs
(
    input  wire                          pclk,
    input  wire                          s_pclk_rstn,
    input  wire                          i_psel,
    input  wire                          i_penable,
    input  wire                          i_pwrite,
    input  wire [`APP_ADDR_W-1:0]        i_paddr,
    input  wire [`APP_DATA_W-1:0]        i_pwdata,
    output logic                         o_pready,
    output logic [`APP_DATA_W-1:0]       o_prdata,
    output logic                         o_pslverr,
    cfg_access_if.regs                   acc,
    output pcie_app_pkg::path_mode_e     o_req_mode,
    input  pcie_app_pkg::path_mode_e     i_active_mode,
    input  wire [`APP_DATA_W-1:0]        i_rx_pkts,
    input  wire [`APP_DATA_W-1:0]        i_rx_csum,
    output logic                         o_rx_clear
);

    logic                   access;    // apb access phase
    logic                   wr;
    logic                   rd;
    logic                   ctrl_wr;
    logic                   err;
    logic [`APP_DATA_W-1:0] rdata;

    assign access   = i_psel & i_penable;
    assign wr       = access & i_pwrite;
    assign rd       = access & ~i_pwrite;
    assign o_pready = access;          // no wait states

    // ************************************************************************
    // address decode and read mux
    // ************************************************************************
    always_comb
    begin
        rdata         = '0;
        err           = 1'b0;
        ctrl_wr       = 1'b0;
        o_rx_clear    = 1'b0;
        acc.push      = 1'b0;
        acc.push_last = 1'b0;
        acc.pop       = 1'b0;
        case (i_paddr)
            pcie_app_pkg::REG_CTRL:
            begin
                rdata[0] = o_req_mode;
                ctrl_wr  = wr;
            end
            pcie_app_pkg::REG_STATUS:
            begin
                rdata[2:0] = {acc.rx_nempty, acc.tx_full, i_active_mode};
                err        = i_pwrite;
            end
            pcie_app_pkg::REG_TX_DATA,
            pcie_app_pkg::REG_TX_LAST:
            begin
                acc.push      = wr & ~acc.tx_full;
                acc.push_last = (i_paddr == pcie_app_pkg::REG_TX_LAST);
                err           = i_pwrite & acc.tx_full;   // word dropped
            end
            pcie_app_pkg::REG_RX_DATA:
            begin
                rdata   = acc.rx_nempty ? acc.pop_data : '0;
                acc.pop = rd & acc.rx_nempty;
                err     = i_pwrite;
            end
            pcie_app_pkg::REG_RX_PKTS:
            begin
                rdata      = i_rx_pkts;
                o_rx_clear = wr;       // any written value clears
            end
            pcie_app_pkg::REG_RX_CSUM:
            begin
                rdata = i_rx_csum;
                err   = i_pwrite;
            end
            default:   err = 1'b1;
        endcase
    end

    assign acc.push_data = i_pwdata;
    assign o_prdata      = access ? rdata : '0;
    assign o_pslverr     = access & err;

    // requested mode register
    always_ff @(posedge pclk or negedge s_pclk_rstn)
    begin
        if (!s_pclk_rstn)
            o_req_mode <= pcie_app_pkg::MODE_DMA;
        else if (ctrl_wr)
            o_req_mode <= pcie_app_pkg::path_mode_e'(i_pwdata[0]);
    end

endmodule

`default_nettype wire

// File: rtl/word_fifo.sv
// show-ahead fifo of data words with a last flag, used for configuration tlp buffering
`default_nettype none

`include "pcie_app_settings.svh"

module word_fifo
#(
    parameter int DEPTH = `APP_FIFO_DEPTH
)
(
    input  wire                    pclk,
    input  wire                    s_pclk_rstn,
    input  wire                    i_wr,
    input  wire [`APP_DATA_W-1:0]  i_wdata,
    input  wire                    i_wlast,
    input  wire                    i_rd,
    output logic [`APP_DATA_W-1:0] o_rdata,
    output logic                   o_rlast,
    output logic                   o_full,
    output logic                   o_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`APP_DATA_W:0] mem [DEPTH];    // {last, data}
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 do_wr;
    logic                 do_rd;

    assign do_wr = i_wr & ~o_full;        // write when full is ignored
    assign do_rd = i_rd & ~o_empty;

    always_ff @(posedge pclk)
    begin
        if (do_wr)
            mem[wr_ptr] <= {i_wlast, i_wdata};
    end

    always_ff @(posedge pclk or negedge s_pclk_rstn)
    begin
        if (!s_pclk_rstn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign {o_rlast, o_rdata} = mem[rd_ptr];  // head word, valid when not empty
    assign o_full             = (count == CNT_W'(DEPTH));
    assign o_empty            = (count == '0);

endmodule

`default_nettype wire

// File: rtl/cfg_tlp_engine.sv
// configuration tlp engine: apb-filled transmit buffer and apb-drained receive buffer
`default_nettype none

module cfg_tlp_engine
(
    input  wire           pclk,
    input  wire           s_pclk_rstn,
    cfg_access_if.engine  acc,
    app_stream_if.src     tx,
    app_stream_if.snk     rx
);

    logic tx_empty;
    logic rx_full;
    logic rx_empty;

    // tx side, apb pushes in, stream drains out
    word_fifo u_tx_fifo
    (
        .pclk        (pclk                   ),
        .s_pclk_rstn (s_pclk_rstn            ),
        .i_wr        (acc.push               ),
        .i_wdata     (acc.push_data          ),
        .i_wlast     (acc.push_last          ),
        .i_rd        (tx.tvalid & tx.tready  ),
        .o_rdata     (tx.tdata               ),
        .o_rlast     (tx.tlast               ),
        .o_full      (acc.tx_full            ),
        .o_empty     (tx_empty               )
    );

    assign tx.tvalid = ~tx_empty;

    // rx side, stream fills, apb pops
    word_fifo u_rx_fifo
    (
        .pclk        (pclk                   ),
        .s_pclk_rstn (s_pclk_rstn            ),
        .i_wr        (rx.tvalid & rx.tready  ),
        .i_wdata     (rx.tdata               ),
        .i_wlast     (rx.tlast               ),
        .i_rd        (acc.pop                ),
        .o_rdata     (acc.pop_data           ),
        .o_rlast     (                       ),     // packet framing not exposed to apb
        .o_full      (rx_full                ),
        .o_empty     (rx_empty               )
    );

    assign rx.tready     = ~rx_full;
    assign acc.rx_nempty = ~rx_empty;

endmodule

`default_nettype wire

// File: rtl/rx_checksum_unit.sv
// normal-mode receive sink: counts packets and folds every word into an xor checksum
`default_nettype none

`include "pcie_app_settings.svh"

module rx_checksum_unit
(
    input  wire                    pclk,
    input  wire                    s_pclk_rstn,
    app_stream_if.snk              rx,
    input  wire                    i_clear,
    output logic [`APP_DATA_W-1:0] o_pkts,
    output logic [`APP_DATA_W-1:0] o_csum
);

    logic beat;

    assign rx.tready = 1'b1;              // never back-pressures
    assign beat      = rx.tvalid & rx.tready;

    always_ff @(posedge pclk or negedge s_pclk_rstn)
    begin
        if (!s_pclk_rstn)
        begin
            o_pkts <= '0;
            o_csum <= '0;
        end
        else if (i_clear)                 // clear beats a same-cycle word
        begin
            o_pkts <= '0;
            o_csum <= '0;
        end
        else if (beat)
        begin
            o_csum <= o_csum ^ rx.tdata;
            if (rx.tlast)
                o_pkts <= o_pkts + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/stream_path_sel.sv
// stream path selector: steers rx, gates tx and moves the active mode only between packets
`default_nettype none

`include "pcie_app_settings.svh"

module stream_path_sel
(
    input  wire                          pclk,
    input  wire                          s_pclk_rstn,
    input  pcie_app_pkg::path_mode_e     i_req_mode,
    output pcie_app_pkg::path_mode_e     o_active_mode,
    app_stream_if.snk                    rx_in,
    app_stream_if.src                    rx_cfg,
    app_stream_if.src                    rx_dma,
    app_stream_if.snk                    tx_cfg,
    output logic                         o_tx_tvalid,
    output logic [`APP_DATA_W-1:0]       o_tx_tdata,
    output logic                         o_tx_tlast,
    input  wire                          i_tx_tready
);

    logic cfg_on;
    logic rx_beat;
    logic tx_beat;
    logic rx_pkt;        // rx packet open
    logic tx_pkt;        // tx packet open
    logic rx_pkt_nxt;
    logic tx_pkt_nxt;

    assign cfg_on = (o_active_mode == pcie_app_pkg::MODE_CFG);

    // rx steering, both sinks see the data, only one sees valid
    assign rx_cfg.tvalid = rx_in.tvalid & cfg_on;
    assign rx_cfg.tdata  = rx_in.tdata;
    assign rx_cfg.tlast  = rx_in.tlast;
    assign rx_dma.tvalid = rx_in.tvalid & ~cfg_on;
    assign rx_dma.tdata  = rx_in.tdata;
    assign rx_dma.tlast  = rx_in.tlast;
    assign rx_in.tready  = cfg_on ? rx_cfg.tready : rx_dma.tready;

    // tx idle in dma mode
    assign o_tx_tvalid   = tx_cfg.tvalid & cfg_on;
    assign o_tx_tdata    = cfg_on ? tx_cfg.tdata : '0;
    assign o_tx_tlast    = tx_cfg.tlast & cfg_on;
    assign tx_cfg.tready = i_tx_tready & cfg_on;

    assign rx_beat = rx_in.tvalid & rx_in.tready;
    assign tx_beat = o_tx_tvalid & i_tx_tready;

    // a beat without last opens a packet, the last beat closes it
    assign rx_pkt_nxt = rx_beat ? ~rx_in.tlast : rx_pkt;
    assign tx_pkt_nxt = tx_beat ? ~o_tx_tlast : tx_pkt;

    // ************************************************************************
    // packet tracking and mode switch
    // ************************************************************************
    always_ff @(posedge pclk or negedge s_pclk_rstn)
    begin
        if (!s_pclk_rstn)
        begin
            rx_pkt        <= 1'b0;
            tx_pkt        <= 1'b0;
            o_active_mode <= pcie_app_pkg::MODE_DMA;
        end
        else
        begin
            rx_pkt <= rx_pkt_nxt;
            tx_pkt <= tx_pkt_nxt;
            if (!rx_pkt_nxt && !tx_pkt_nxt)   // both streams at a boundary
                o_active_mode <= i_req_mode;
        end
    end

endmodule

`default_nettype wire

// File: rtl/pcie_app_top.sv
// application-side top level: apb registers, configuration tlp engine and dma receive path
`default_nettype none

`include "pcie_app_settings.svh"

module pcie_app_top
(
    input  wire                    pclk,
    input  wire                    s_pclk_rstn,
    // apb
    input  wire                    i_psel,
    input  wire                    i_penable,
    input  wire                    i_pwrite,
    input  wire [`APP_ADDR_W-1:0]  i_paddr,
    input  wire [`APP_DATA_W-1:0]  i_pwdata,
    output logic                   o_pready,
    output logic [`APP_DATA_W-1:0] o_prdata,
    output logic                   o_pslverr,
    // receive stream
    input  wire                    i_rx_tvalid,
    input  wire [`APP_DATA_W-1:0]  i_rx_tdata,
    input  wire                    i_rx_tlast,
    output logic                   o_rx_tready,
    // transmit stream
    output logic                   o_tx_tvalid,
    output logic [`APP_DATA_W-1:0] o_tx_tdata,
    output logic                   o_tx_tlast,
    input  wire                    i_tx_tready
);

    app_stream_if rx_in ();
    app_stream_if rx_cfg ();
    app_stream_if rx_dma ();
    app_stream_if tx_cfg ();
    cfg_access_if acc ();

    pcie_app_pkg::path_mode_e req_mode;
    pcie_app_pkg::path_mode_e active_mode;
    logic [`APP_DATA_W-1:0]   rx_pkts;
    logic [`APP_DATA_W-1:0]   rx_csum;
    logic                     rx_clear;

    assign rx_in.tvalid = i_rx_tvalid;
    assign rx_in.tdata  = i_rx_tdata;
    assign rx_in.tlast  = i_rx_tlast;
    assign o_rx_tready  = rx_in.tready;

    app_regs u_app_regs
    (
        .pclk          (pclk        ),
        .s_pclk_rstn   (s_pclk_rstn ),
        .i_psel        (i_psel      ),
        .i_penable     (i_penable   ),
        .i_pwrite      (i_pwrite    ),
        .i_paddr       (i_paddr     ),
        .i_pwdata      (i_pwdata    ),
        .o_pready      (o_pready    ),
        .o_prdata      (o_prdata    ),
        .o_pslverr     (o_pslverr   ),
        .acc           (acc.regs    ),
        .o_req_mode    (req_mode    ),
        .i_active_mode (active_mode ),
        .i_rx_pkts     (rx_pkts     ),
        .i_rx_csum     (rx_csum     ),
        .o_rx_clear    (rx_clear    )
    );

    cfg_tlp_engine u_cfg_tlp_engine
    (
        .pclk        (pclk        ),
        .s_pclk_rstn (s_pclk_rstn ),
        .acc         (acc.engine  ),
        .tx          (tx_cfg.src  ),
        .rx          (rx_cfg.snk  )
    );

    rx_checksum_unit u_rx_checksum_unit
    (
        .pclk        (pclk        ),
        .s_pclk_rstn (s_pclk_rstn ),
        .rx          (rx_dma.snk  ),
        .i_clear     (rx_clear    ),
        .o_pkts      (rx_pkts     ),
        .o_csum      (rx_csum     )
    );

    stream_path_sel u_stream_path_sel
    (
        .pclk          (pclk        ),
        .s_pclk_rstn   (s_pclk_rstn ),
        .i_req_mode    (req_mode    ),
        .o_active_mode (active_mode ),
        .rx_in         (rx_in.snk   ),
        .rx_cfg        (rx_cfg.src  ),
        .rx_dma        (rx_dma.src  ),
        .tx_cfg        (tx_cfg.snk  ),
        .o_tx_tvalid   (o_tx_tvalid ),
        .o_tx_tdata    (o_tx_tdata  ),
        .o_tx_tlast    (o_tx_tlast  ),
        .i_tx_tready   (i_tx_tready )
    );

endmodule

`default_nettype wire

// File: verif/pcie_app_tb.sv
// directed testbench for the pcie application top level and the simulation top in flist.f
`default_nettype none

`include "pcie_app_settings.svh"

module pcie_app_tb;

    localparam int W      = `APP_DATA_W;
    localparam int DEPTH  = `APP_FIFO_DEPTH;
    localparam int PERIOD = 100;
    localparam int BUDGET = 40 + 200 + 300 + 150 + 300 + 200;  // cycle budget with one term per test

    logic                   pclk;
    logic                   s_pclk_rstn;
    logic                   i_psel;
    logic                   i_penable;
    logic                   i_pwrite;
    logic [`APP_ADDR_W-1:0] i_paddr;
    logic [W-1:0]           i_pwdata;
    logic                   o_pready;
    logic [W-1:0]           o_prdata;
    logic                   o_pslverr;
    logic                   i_rx_tvalid;
    logic [W-1:0]           i_rx_tdata;
    logic                   i_rx_tlast;
    logic                   o_rx_tready;
    logic                   o_tx_tvalid;
    logic [W-1:0]           o_tx_tdata;
    logic                   o_tx_tlast;
    logic                   i_tx_tready;

    logic [31:0]  lfsr_state = 32'h0502_9463;
    logic [W-1:0] exp_words [DEPTH+1];      // expected tx or rx words in order

    pcie_app_top i_pcie_app_top
    (
        .pclk        (pclk        ),
        .s_pclk_rstn (s_pclk_rstn ),
        .i_psel      (i_psel      ),
        .i_penable   (i_penable   ),
        .i_pwrite    (i_pwrite    ),
        .i_paddr     (i_paddr     ),
        .i_pwdata    (i_pwdata    ),
        .o_pready    (o_pready    ),
        .o_prdata    (o_prdata    ),
        .o_pslverr   (o_pslverr   ),
        .i_rx_tvalid (i_rx_tvalid ),
        .i_rx_tdata  (i_rx_tdata  ),
        .i_rx_tlast  (i_rx_tlast  ),
        .o_rx_tready (o_rx_tready ),
        .o_tx_tvalid (o_tx_tvalid ),
        .o_tx_tdata  (o_tx_tdata  ),
        .o_tx_tlast  (o_tx_tlast  ),
        .i_tx_tready (i_tx_tready )
    );

    initial
    begin
        pclk = 1'b0;
        forever #(PERIOD / 2) pclk = ~pclk;
    end

    // ************************************************************************
    // reporting and random bits
    // ************************************************************************
    task automatic stop_run(input string msg);
        begin
            $display("%s", msg);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic check(input string name, input logic [W-1:0] got, input logic [W-1:0] exp);
        begin
            if (got !== exp)
                stop_run($sformatf("[ERROR] %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    initial
    begin
        #(BUDGET * PERIOD);
        stop_run("watchdog timeout, the tests did not finish in their cycle budget");
    end

    // galois lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        begin
            lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
        end
    endfunction

    task automatic rand_bits(input int n, output logic [W-1:0] bits);
        int i;
        begin
            bits = '0;
            for (i = 0; i < n; i++)
            begin
                lfsr_state = lfsr_step(lfsr_state);
                bits       = {bits[W-2:0], lfsr_state[0]};
            end
        end
    endtask

    // ************************************************************************
    // bus and stream drivers on the falling edge
    // ************************************************************************
    task automatic apb_xfer(input logic write, input logic [`APP_ADDR_W-1:0] addr,
                            input logic [W-1:0] wdata, output logic [W-1:0] rdata,
                            output logic err);
        begin
            @(negedge pclk);
            i_psel    = 1'b1;                // setup phase
            i_penable = 1'b0;
            i_pwrite  = write;
            i_paddr   = addr;
            i_pwdata  = wdata;
            @(negedge pclk);
            i_penable = 1'b1;
            @(posedge pclk);                 // pre-edge values of the access phase
            check("o_pready", o_pready, 1);
            rdata = o_prdata;
            err   = o_pslverr;
            @(negedge pclk);
            i_psel    = 1'b0;
            i_penable = 1'b0;
        end
    endtask

    task automatic apb_write(input logic [`APP_ADDR_W-1:0] addr, input logic [W-1:0] data,
                             output logic err);
        logic [W-1:0] unused;
        begin
            apb_xfer(1'b1, addr, data, unused, err);
        end
    endtask

    task automatic apb_read(input logic [`APP_ADDR_W-1:0] addr, output logic [W-1:0] data,
                            output logic err);
        begin
            apb_xfer(1'b0, addr, '0, data, err);
        end
    endtask

    task automatic rx_send(input logic [W-1:0] data, input logic last);
        begin
            @(negedge pclk);
            i_rx_tvalid = 1'b1;
            i_rx_tdata  = data;
            i_rx_tlast  = last;
            @(posedge pclk);
            while (!o_rx_tready)
                @(posedge pclk);
            @(negedge pclk);
            i_rx_tvalid = 1'b0;
        end
    endtask

    // takes n tx beats under random back-pressure with last on beat n-1
    task automatic collect_tx(input int n);
        int           idx;
        logic [W-1:0] r;
        begin
            idx = 0;
            while (idx < n)
            begin
                @(negedge pclk);
                rand_bits(1, r);
                i_tx_tready = r[0];
                @(posedge pclk);
                if (o_tx_tvalid && i_tx_tready)
                begin
                    check("o_tx_tdata", o_tx_tdata, exp_words[idx]);
                    check("o_tx_tlast", o_tx_tlast, idx == n - 1);
                    idx++;
                end
            end
            @(negedge pclk);
            i_tx_tready = 1'b0;
            check("o_tx_tvalid", o_tx_tvalid, 0);    // nothing beyond the packet
        end
    endtask

    task automatic wait_mode(input logic mode);
        logic [W-1:0] d;
        logic         err;
        int           polls;
        begin
            polls = 0;
            apb_read(pcie_app_pkg::REG_STATUS, d, err);
            while (d[0] !== mode)
            begin
                polls++;
                if (polls > 20)
                    stop_run("active mode did not follow the requested mode");
                apb_read(pcie_app_pkg::REG_STATUS, d, err);
            end
        end
    endtask

    // ************************************************************************
    // directed tests
    // ************************************************************************
    task automatic reset_state_reads;
        logic [W-1:0] d;
        logic         err;
        begin
            check("o_tx_tvalid", o_tx_tvalid, 0);
            check("o_pready", o_pready, 0);
            apb_read(pcie_app_pkg::REG_CTRL, d, err);
            check("reg_ctrl", d, 0);
            check("o_pslverr", err, 0);
            apb_read(pcie_app_pkg::REG_STATUS, d, err);
            check("reg_status", d, 0);
        end
    endtask

    task automatic normal_mode_receive;
        logic [W-1:0] w;
        logic [W-1:0] d;
        logic [W-1:0] csum;
        logic         err;
        int           p;
        int           i;
        begin
            csum = '0;
            for (p = 0; p < 3; p++)
            begin
                for (i = 0; i < p + 2; i++)  // 2, 3 and 4 words
                begin
                    rand_bits(W, w);
                    csum = csum ^ w;
                    rx_send(w, i == p + 1);
                end
            end
            apb_read(pcie_app_pkg::REG_RX_PKTS, d, err);
            check("reg_rx_pkts", d, 3);
            apb_read(pcie_app_pkg::REG_RX_CSUM, d, err);
            check("reg_rx_csum", d, csum);
            apb_write(pcie_app_pkg::REG_RX_PKTS, 32'hFFFF_FFFF, err);
            check("o_pslverr", err, 0);
            apb_read(pcie_app_pkg::REG_RX_PKTS, d, err);
            check("reg_rx_pkts", d, 0);
            apb_read(pcie_app_pkg::REG_RX_CSUM, d, err);
            check("reg_rx_csum", d, 0);
        end
    endtask

    task automatic config_transmit;
        logic err;
        int   i;
        begin
            apb_write(pcie_app_pkg::REG_CTRL, 1, err);
            check("o_pslverr", err, 0);
            wait_mode(1'b1);
            for (i = 0; i < 4; i++)
            begin
                rand_bits(W, exp_words[i]);
                apb_write((i == 3) ? pcie_app_pkg::REG_TX_LAST : pcie_app_pkg::REG_TX_DATA,
                          exp_words[i], err);
                check("o_pslverr", err, 0);
            end
            collect_tx(4);
        end
    endtask

    task automatic config_receive;
        logic [W-1:0] d;
        logic         err;
        int           i;
        begin
            for (i = 0; i < DEPTH; i++)
            begin
                rand_bits(W, exp_words[i]);
                rx_send(exp_words[i], i == DEPTH - 1);
            end
            check("o_rx_tready", o_rx_tready, 0);    // receive fifo full
            apb_read(pcie_app_pkg::REG_STATUS, d, err);
            check("status rx not empty", d[2], 1);
            for (i = 0; i < DEPTH; i++)
            begin
                apb_read(pcie_app_pkg::REG_RX_DATA, d, err);
                check("reg_rx_data", d, exp_words[i]);
                check("o_pslverr", err, 0);
            end
            apb_read(pcie_app_pkg::REG_RX_DATA, d, err);   // fifo now empty
            check("reg_rx_data", d, 0);
            check("o_pslverr", err, 0);
            check("o_rx_tready", o_rx_tready, 1);
        end
    endtask

    task automatic error_responses;
        logic [W-1:0] d;
        logic         err;
        int           i;
        begin
            for (i = 0; i < DEPTH; i++)
            begin
                rand_bits(W, exp_words[i]);
                apb_write((i == DEPTH - 1) ? pcie_app_pkg::REG_TX_LAST :
                          pcie_app_pkg::REG_TX_DATA, exp_words[i], err);
                check("o_pslverr", err, 0);
            end
            apb_read(pcie_app_pkg::REG_STATUS, d, err);
            check("status tx full", d[1], 1);
            apb_write(pcie_app_pkg::REG_TX_DATA, 32'hDEAD_BEEF, err);
            check("o_pslverr on full push", err, 1);
            collect_tx(DEPTH);
            apb_read(12'h020, d, err);
            check("o_pslverr on unmapped", err, 1);
        end
    endtask

    task automatic deferred_mode_switch;
        logic [W-1:0] w0;
        logic [W-1:0] w1;
        logic [W-1:0] d;
        logic         err;
        begin
            apb_write(pcie_app_pkg::REG_CTRL, 0, err);
            wait_mode(1'b0);
            apb_write(pcie_app_pkg::REG_RX_PKTS, 0, err);
            rand_bits(W, w0);
            rand_bits(W, w1);
            rx_send(w0, 1'b0);               // packet left open
            apb_write(pcie_app_pkg::REG_CTRL, 1, err);
            apb_read(pcie_app_pkg::REG_STATUS, d, err);
            check("active mode in packet", d[0], 0);
            apb_read(pcie_app_pkg::REG_STATUS, d, err);
            check("active mode in packet", d[0], 0);
            rx_send(w1, 1'b1);
            apb_read(pcie_app_pkg::REG_STATUS, d, err);
            check("active mode after packet", d[0], 1);
            apb_read(pcie_app_pkg::REG_RX_CSUM, d, err);
            check("reg_rx_csum", d, w0 ^ w1);
            apb_read(pcie_app_pkg::REG_RX_PKTS, d, err);
            check("reg_rx_pkts", d, 1);
        end
    endtask

    initial
    begin
        i_psel      = 1'b0;
        i_penable   = 1'b0;
        i_pwrite    = 1'b0;
        i_paddr     = '0;
        i_pwdata    = '0;
        i_rx_tvalid = 1'b0;
        i_rx_tdata  = '0;
        i_rx_tlast  = 1'b0;
        i_tx_tready = 1'b0;
        s_pclk_rstn = 1'b0;
        repeat (5) @(posedge pclk);
        @(negedge pclk);
        s_pclk_rstn = 1'b1;

        reset_state_reads;
        normal_mode_receive;
        config_transmit;
        config_receive;
        error_responses;
        deferred_mode_switch;

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+rtl
rtl/pcie_app_pkg.sv
rtl/app_stream_if.sv
rtl/app_regs.sv
rtl/word_fifo.sv
rtl/cfg_tlp_engine.sv
rtl/rx_checksum_unit.sv
rtl/stream_path_sel.sv
rtl/pcie_app_top.sv
verif/pcie_app_tb.sv
